/* fdc_io.f */
logic/fdc_pkg.sv
logic/fdc_io_decode.sv
logic/fdc_uart_tx.sv
logic/fdc_spi_master.sv
logic/fdc_countdown.sv
logic/fdc_io_regfile.sv
logic/fdc_io.sv
tb/fdc_io_props.sv
tb/fdc_io_tb.sv

/* Makefile */
# Verilator build and run for the fdc_io peripheral block

VERILATOR ?= verilator
TOP       ?= fdc_io_tb
FILELIST  ?= fdc_io.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass or fail comes from the simulation output alone
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* tb/fdc_io_tb.sv */
`timescale 1ns/10ps

module fdc_io_tb;
	import fdc_pkg::*;

	// Byte the SD card model answers with
	localparam logic [7:0] spi_reply = 8'h3C;

	logic clk;
	logic reset_n;
	logic [15:0] addr;
	logic [7:0] wdata;
	logic wr;
	logic ce;
	logic sd_dat;
	logic [7:0] rdata;
	logic uart_txd;
	logic sd_clk;
	logic sd_cmd;
	logic sd_cs;
	logic [7:0] green_leds;

	int seed = 41;
	int errors = 0;
	int timeouts = 0;
	int cycles = 0;

	logic [7:0] slave_tx;
	logic [7:0] slave_rx;

	fdc_io dut0 (
		.clk(clk),
		.reset_n(reset_n),
		.addr(addr),
		.wdata(wdata),
		.wr(wr),
		.ce(ce),
		.sd_dat(sd_dat),
		.rdata(rdata),
		.uart_txd(uart_txd),
		.sd_clk(sd_clk),
		.sd_cmd(sd_cmd),
		.sd_cs(sd_cs),
		.green_leds(green_leds)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
	end

	////////////////////////////////////////////////////////////
	// SD card model, SPI mode 0
	////////////////////////////////////////////////////////////

	always @(posedge sd_clk) begin
		if (reset_n)
			slave_rx <= {slave_rx[6:0], sd_cmd};
	end

	// Reply rotates, so it is ready again after eight bits
	always @(negedge sd_clk) begin
		if (reset_n) begin
			#5;
			slave_tx = {slave_tx[6:0], slave_tx[7]};
			sd_dat = slave_tx[7];
		end
	end

	////////////////////////////////////////////////////////////
	// Bus master and checks
	////////////////////////////////////////////////////////////

	function automatic logic [15:0] port_addr(input logic [7:0] offset);
		return io_base | {8'h00, offset};
	endfunction

	task automatic bus_write(input logic [15:0] a, input logic [7:0] d, input logic ce_val);
		@(posedge clk);
		#5;
		addr = a;
		wdata = d;
		wr = 1'b1;
		ce = ce_val;
		@(posedge clk);
		#5;
		wr = 1'b0;
		ce = 1'b0;
	endtask

	// Address in, rd_port at the next edge, rdata one edge later
	task automatic bus_read(input logic [15:0] a, output logic [7:0] d);
		@(posedge clk);
		#5;
		addr = a;
		@(posedge clk);
		@(posedge clk);
		#5;
		d = rdata;
	endtask

	task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("MISMATCH at %0t: %s is %02h, expected %02h", $time, what, got, exp);
		end
	endtask

	task automatic check_true(input logic cond, input string msg);
		assert (cond === 1'b1) else begin
			errors++;
			$display("MISMATCH at %0t: %s", $time, msg);
		end
	endtask

	task automatic poll_bit(input logic [15:0] a, input logic want, input int limit,
		input string what);
		logic [7:0] d;
		int start;
		start = cycles;
		bus_read(a, d);
		while (d[0] !== want && cycles - start < limit)
			bus_read(a, d);
		if (d[0] !== want) begin
			timeouts++;
			$display("Timeout: gave up waiting for %s after %0d cycles", what, limit);
		end
	endtask

	// Samples uart_txd in the middle of each bit
	task automatic uart_receive(output logic [7:0] data, output logic frame_ok);
		int waited;
		waited = 0;
		data = 8'h00;
		frame_ok = 1'b0;
		@(posedge clk);
		#5;
		while (uart_txd !== 1'b0 && waited < 4 * uart_div) begin
			@(posedge clk);
			#5;
			waited++;
		end
		if (uart_txd !== 1'b0) begin
			timeouts++;
			$display("Timeout: no start bit on uart_txd within %0d cycles", 4 * uart_div);
		end else begin
			repeat (uart_div / 2) @(posedge clk);
			#5;
			frame_ok = uart_txd === 1'b0;
			for (int i = 0; i < 8; i++) begin
				repeat (uart_div) @(posedge clk);
				#5;
				data[i] = uart_txd;
			end
			repeat (uart_div) @(posedge clk);
			#5;
			frame_ok = frame_ok && uart_txd === 1'b1;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		logic [7:0] d;
		logic [7:0] b;
		logic [7:0] got;
		logic ok;
		logic [7:0] t1;
		logic [7:0] t2;
		logic [7:0] prev1;
		logic [7:0] prev2;
		int low_cnt;
		int start;

		clk = 1'b0;
		reset_n = 1'b1;
		addr = 16'h0000;
		wdata = 8'h00;
		wr = 1'b0;
		ce = 1'b0;
		slave_tx = spi_reply;
		slave_rx = 8'h00;
		sd_dat = spi_reply[7];
		// Falling edge on reset_n before the first clock
		#10;
		reset_n = 1'b0;
		repeat (5) @(posedge clk);
		#5;
		reset_n = 1'b1;

		// Reset state and unmapped reads
		bus_read(port_addr(port_ctl), d);
		check_byte("port_ctl", d, 8'h00);
		bus_read(port_addr(port_spsr), d);
		check_byte("port_spsr", d, 8'h00);
		bus_read(port_addr(port_tmr1), d);
		check_byte("port_tmr1", d, 8'h00);
		bus_read(port_addr(port_tmr2), d);
		check_byte("port_tmr2", d, 8'h00);
		bus_read(16'h1234, d);
		check_byte("read outside the window", d, 8'hFF);
		bus_read(port_addr(8'h03), d);
		check_byte("read of unused offset", d, 8'hFF);
		check_true(uart_txd, "uart_txd is not high after reset");
		check_true(sd_cs, "sd_cs is not high after reset");
		check_byte("green_leds", green_leds, 8'h00);

		// LED and card select registers
		b = 8'($random(seed));
		bus_write(port_addr(port_led), b, 1'b1);
		@(posedge clk);
		#5;
		check_byte("green_leds", green_leds, b);
		bus_write(port_addr(port_mmca), 8'h00, 1'b1);
		@(posedge clk);
		#5;
		check_true(sd_cs === 1'b0, "sd_cs did not drop after writing 0 to port_mmca");
		bus_write(port_addr(port_mmca), 8'h01, 1'b1);
		@(posedge clk);
		#5;
		check_true(sd_cs === 1'b1, "sd_cs did not rise after writing 1 to port_mmca");
		bus_write(port_addr(port_led), ~b, 1'b0);
		repeat (2) @(posedge clk);
		#5;
		check_byte("green_leds after a write with ce low", green_leds, b);

		// One serial frame, second write lands while busy
		b = 8'($random(seed));
		bus_write(port_addr(port_txd), b, 1'b1);
		fork
			uart_receive(got, ok);
			begin
				bus_read(port_addr(port_ctl), d);
				check_byte("port_ctl while sending", d, 8'h01);
				bus_write(port_addr(port_txd), ~b, 1'b1);
			end
		join
		check_byte("received serial byte", got, b);
		check_true(ok, "serial frame has a bad start or stop bit");
		poll_bit(port_addr(port_ctl), 1'b0, 4 * uart_div, "the transmitter to go idle");
		low_cnt = 0;
		repeat (12 * uart_div) begin
			@(posedge clk);
			#5;
			if (uart_txd !== 1'b1)
				low_cnt++;
		end
		check_true(low_cnt == 0, "uart_txd sent a frame for a write made while busy");

		// SPI exchanges
		repeat (4) begin
			b = 8'($random(seed));
			bus_write(port_addr(port_spdr), b, 1'b1);
			poll_bit(port_addr(port_spsr), 1'b1, 16 * spi_half + 20, "the SPI exchange to finish");
			check_byte("byte seen by the SD card model", slave_rx, b);
			bus_read(port_addr(port_spdr), d);
			check_byte("port_spdr", d, spi_reply);
		end

		// Timers count down and hold at zero
		bus_write(port_addr(port_tmr1), 8'd5, 1'b1);
		bus_write(port_addr(port_tmr2), 8'd200, 1'b1);
		start = cycles;
		prev1 = 8'd5;
		prev2 = 8'd200;
		t1 = 8'd5;
		t2 = 8'd200;
		while (t1 != 8'd0 && cycles - start < 5 * tick_div + 10) begin
			bus_read(port_addr(port_tmr1), t1);
			bus_read(port_addr(port_tmr2), t2);
			check_true(t1 <= prev1, "port_tmr1 read went up");
			check_true(t2 <= prev2, "port_tmr2 read went up");
			prev1 = t1;
			prev2 = t2;
		end
		if (t1 != 8'd0) begin
			timeouts++;
			$display("Timeout: tmr1 did not reach zero within %0d cycles", 5 * tick_div + 10);
		end
		check_true(t2 != 8'd0, "tmr2 reached zero as early as tmr1");
		repeat (3) begin
			repeat (tick_div) @(posedge clk);
			bus_read(port_addr(port_tmr1), d);
			check_byte("port_tmr1 after expiry", d, 8'h00);
		end

		errors = errors + dut0.props0.fail_count;
		$display("Closing: %0d errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

/* tb/fdc_io_props.sv */
`timescale 1ns/10ps

module fdc_io_props (
	input  logic clk,
	input  logic reset_n,
	input  logic [15:0] addr,
	input  logic [7:0] rdata,
	input  logic uart_txd,
	input  logic sd_clk,
	input  logic sd_cmd,
	input  logic sd_cs,
	input  logic [7:0] green_leds,
	input  logic wr_txd,
	input  logic tx_busy,
	input  logic spi_done,
	input  logic [7:0] tmr1_q,
	input  logic [7:0] tmr2_q,
	input  fdc_pkg::uart_state_e tx_st,
	input  fdc_pkg::spi_state_e spi_st
);
	import fdc_pkg::*;

	// Read back by the testbench at the end of the run
	int fail_count = 0;

	////////////////////////////////////////////////////////////
	// Reset state
	////////////////////////////////////////////////////////////

	reset_values: assert property (@(posedge clk)
		!reset_n |-> uart_txd && !tx_busy && !sd_clk && !sd_cmd && sd_cs
			&& green_leds == 8'h00 && tmr1_q == 8'h00 && tmr2_q == 8'h00
			&& !spi_done && rdata == 8'hFF)
		else begin
			fail_count++;
			$error("outputs are not at their reset values while reset is held");
		end

	////////////////////////////////////////////////////////////
	// Device timing
	////////////////////////////////////////////////////////////

	busy_after_load: assert property (@(posedge clk) disable iff (!reset_n)
		wr_txd && tx_st == tx_idle |=> tx_busy)
		else begin
			fail_count++;
			$error("tx_busy did not rise one cycle after a transmit write");
		end

	// Mode 0 keeps sck low between bytes
	sck_low_idle: assert property (@(posedge clk) disable iff (!reset_n)
		spi_st == spi_idle |-> !sd_clk)
		else begin
			fail_count++;
			$error("sd_clk is high while the SPI master is idle");
		end

	// Address, then rd_port, then rdata
	unmapped_read: assert property (@(posedge clk) disable iff (!reset_n)
		addr[15:8] != io_base[15:8] |-> ##2 rdata == 8'hFF)
		else begin
			fail_count++;
			$error("an address outside the window did not read back FF");
		end

endmodule

bind fdc_io fdc_io_props props0 (
	.clk(clk),
	.reset_n(reset_n),
	.addr(addr),
	.rdata(rdata),
	.uart_txd(uart_txd),
	.sd_clk(sd_clk),
	.sd_cmd(sd_cmd),
	.sd_cs(sd_cs),
	.green_leds(green_leds),
	.wr_txd(wr_txd),
	.tx_busy(tx_busy),
	.spi_done(spi_done),
	.tmr1_q(tmr1_q),
	.tmr2_q(tmr2_q),
	.tx_st(uart0.state),
	.spi_st(spi0.state)
);

/* logic/fdc_io.sv */
`timescale 1ns/10ps

module fdc_io (
	input  logic clk,
	input  logic reset_n,
	input  logic [15:0] addr,
	input  logic [7:0] wdata,
	input  logic wr,
	input  logic ce,
	input  logic sd_dat,
	output logic [7:0] rdata,
	output logic uart_txd,
	output logic sd_clk,
	output logic sd_cmd,
	output logic sd_cs,
	output logic [7:0] green_leds
);
	import fdc_pkg::*;

	logic [7:0] wdata_q;
	logic wr_txd;
	logic wr_spdr;
	logic wr_tmr1;
	logic wr_tmr2;
	logic wr_mmca;
	logic wr_led;
	io_port_e rd_port;

	logic tx_busy;
	logic spi_done;
	logic [7:0] spi_rx;
	logic [7:0] tmr1_q;
	logic [7:0] tmr2_q;

	////////////////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////////////////

	fdc_io_decode decode0 (
		.clk(clk),
		.reset_n(reset_n),
		.addr(addr),
		.wdata(wdata),
		.wr(wr),
		.ce(ce),
		.wdata_q(wdata_q),
		.wr_txd(wr_txd),
		.wr_spdr(wr_spdr),
		.wr_tmr1(wr_tmr1),
		.wr_tmr2(wr_tmr2),
		.wr_mmca(wr_mmca),
		.wr_led(wr_led),
		.rd_port(rd_port)
	);

	////////////////////////////////////////////////////////////
	// Devices
	////////////////////////////////////////////////////////////

	fdc_uart_tx uart0 (
		.clk(clk),
		.reset_n(reset_n),
		.load(wr_txd),
		.data(wdata_q),
		.txd(uart_txd),
		.busy(tx_busy)
	);

	// SD card in SPI mode, data out of the card is miso
	fdc_spi_master spi0 (
		.clk(clk),
		.reset_n(reset_n),
		.start(wr_spdr),
		.data(wdata_q),
		.miso(sd_dat),
		.sck(sd_clk),
		.mosi(sd_cmd),
		.rx_data(spi_rx),
		.done(spi_done)
	);

	fdc_countdown tmr1 (
		.clk(clk),
		.reset_n(reset_n),
		.load(wr_tmr1),
		.data(wdata_q),
		.value(tmr1_q)
	);

	fdc_countdown tmr2 (
		.clk(clk),
		.reset_n(reset_n),
		.load(wr_tmr2),
		.data(wdata_q),
		.value(tmr2_q)
	);

	////////////////////////////////////////////////////////////
	// Registers and read back
	////////////////////////////////////////////////////////////

	fdc_io_regfile regs0 (
		.clk(clk),
		.reset_n(reset_n),
		.wdata_q(wdata_q),
		.wr_led(wr_led),
		.wr_mmca(wr_mmca),
		.rd_port(rd_port),
		.tx_busy(tx_busy),
		.spi_done(spi_done),
		.spi_rx(spi_rx),
		.tmr1_q(tmr1_q),
		.tmr2_q(tmr2_q),
		.green_leds(green_leds),
		.sd_cs(sd_cs),
		.rdata(rdata)
	);

endmodule

/* logic/fdc_io_regfile.sv */
`timescale 1ns/10ps

module fdc_io_regfile (
	input  logic clk,
	input  logic reset_n,
	input  logic [7:0] wdata_q,
	input  logic wr_led,
	input  logic wr_mmca,
	input  fdc_pkg::io_port_e rd_port,
	input  logic tx_busy,
	input  logic spi_done,
	input  logic [7:0] spi_rx,
	input  logic [7:0] tmr1_q,
	input  logic [7:0] tmr2_q,
	output logic [7:0] green_leds,
	output logic sd_cs,
	output logic [7:0] rdata
);
	import fdc_pkg::*;

	logic [7:0] rd_mux;

	////////////////////////////////////////////////////////////
	// Write-only registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			green_leds <= 8'h00;
			// Card deselected
			sd_cs <= 1'b1;
		end else begin
			if (wr_led)
				green_leds <= wdata_q;
			if (wr_mmca)
				sd_cs <= wdata_q[0];
		end
	end

	////////////////////////////////////////////////////////////
	// Read data
	////////////////////////////////////////////////////////////

	// Unmapped and write-only ports read as all ones
	always_comb begin
		case (rd_port)
			io_ctl: rd_mux = {7'b0, tx_busy};
			io_spsr: rd_mux = {7'b0, spi_done};
			io_spdr: rd_mux = spi_rx;
			io_tmr1: rd_mux = tmr1_q;
			io_tmr2: rd_mux = tmr2_q;
			default: rd_mux = 8'hFF;
		endcase
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n)
			rdata <= 8'hFF;
		else
			rdata <= rd_mux;
	end

endmodule

/* logic/fdc_countdown.sv */
`timescale 1ns/10ps

module fdc_countdown (
	input  logic clk,
	input  logic reset_n,
	input  logic load,
	input  logic [7:0] data,
	output logic [7:0] value
);
	import fdc_pkg::*;

	localparam int pre_w = $clog2(tick_div);

	logic [pre_w-1:0] pre_cnt;
	logic tick;

	assign tick = pre_cnt == pre_w'(tick_div - 1);

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			pre_cnt <= '0;
			value <= '0;
		end else if (load) begin
			// New count restarts the tick period
			pre_cnt <= '0;
			value <= data;
		end else if (tick) begin
			pre_cnt <= '0;
			// Holds at zero
			if (value != 8'd0)
				value <= value - 8'd1;
		end else begin
			pre_cnt <= pre_cnt + 1'b1;
		end
	end

endmodule

/* logic/fdc_spi_master.sv */
`timescale 1ns/10ps

module fdc_spi_master (
	input  logic clk,
	input  logic reset_n,
	input  logic start,
	input  logic [7:0] data,
	input  logic miso,
	output logic sck,
	output logic mosi,
	output logic [7:0] rx_data,
	output logic done
);
	import fdc_pkg::*;

	localparam int half_w = $clog2(spi_half + 1);

	spi_state_e state;
	logic [half_w-1:0] half_cnt;
	logic [2:0] bit_cnt;
	logic [7:0] shreg;
	logic miso_q;
	logic half_end;

	assign half_end = half_cnt == half_w'(spi_half - 1);

	////////////////////////////////////////////////////////////
	// Mode 0 shifter
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state <= spi_idle;
			half_cnt <= '0;
			bit_cnt <= '0;
			shreg <= '0;
			miso_q <= 1'b0;
			sck <= 1'b0;
			done <= 1'b0;
		end else if (state == spi_idle) begin
			if (start) begin
				state <= spi_shift;
				shreg <= data;
				half_cnt <= '0;
				bit_cnt <= '0;
				done <= 1'b0;
			end
		end else if (half_end) begin
			half_cnt <= '0;
			sck <= ~sck;
			if (!sck) begin
				// Rising sck, sample the slave
				miso_q <= miso;
			end else begin
				// Falling sck, shift in sample and present next bit
				shreg <= {shreg[6:0], miso_q};
				bit_cnt <= bit_cnt + 3'd1;
				if (bit_cnt == 3'd7) begin
					state <= spi_idle;
					done <= 1'b1;
				end
			end
		end else begin
			half_cnt <= half_cnt + 1'b1;
		end
	end

	// MSB of the shifter is the line out
	assign mosi = shreg[7];
	// After the eighth bit the shifter holds the received byte
	assign rx_data = shreg;

endmodule

/* logic/fdc_uart_tx.sv */
`timescale 1ns/10ps

module fdc_uart_tx (
	input  logic clk,
	input  logic reset_n,
	input  logic load,
	input  logic [7:0] data,
	output logic txd,
	output logic busy
);
	import fdc_pkg::*;

	localparam int div_w = $clog2(uart_div);

	uart_state_e state;
	logic [div_w-1:0] div_cnt;
	logic [2:0] bit_idx;
	logic [7:0] shreg;
	logic bit_end;

	// Last clock of the current bit time
	assign bit_end = div_cnt == div_w'(uart_div - 1);

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state <= tx_idle;
			div_cnt <= '0;
			bit_idx <= '0;
		end else if (state == tx_idle) begin
			// Load is ignored outside idle
			if (load) begin
				state <= tx_start;
				div_cnt <= '0;
			end
		end else if (bit_end) begin
			div_cnt <= '0;
			case (state)
				tx_start: begin
					state <= tx_data;
					bit_idx <= '0;
				end
				tx_data: begin
					if (bit_idx == 3'd7)
						state <= tx_stop;
					bit_idx <= bit_idx + 3'd1;
				end
				default: state <= tx_idle;
			endcase
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// LSB goes out first
	always_ff @(posedge clk) begin
		if (state == tx_idle && load)
			shreg <= data;
		else if (state == tx_data && bit_end)
			shreg <= {1'b0, shreg[7:1]};
	end

	always_comb begin
		case (state)
			tx_start: txd = 1'b0;
			tx_data: txd = shreg[0];
			default: txd = 1'b1;
		endcase
	end

	assign busy = state != tx_idle;

endmodule

/* logic/fdc_io_decode.sv */
`timescale 1ns/10ps

module fdc_io_decode (
	input  logic clk,
	input  logic reset_n,
	input  logic [15:0] addr,
	input  logic [7:0] wdata,
	input  logic wr,
	input  logic ce,
	output logic [7:0] wdata_q,
	output logic wr_txd,
	output logic wr_spdr,
	output logic wr_tmr1,
	output logic wr_tmr2,
	output logic wr_mmca,
	output logic wr_led,
	output fdc_pkg::io_port_e rd_port
);
	import fdc_pkg::*;

	logic in_window;
	logic wr_hit;
	io_port_e port_sel;

	// Base is 256-aligned, so only the high byte matters
	assign in_window = addr[15:8] == io_base[15:8];
	assign wr_hit = ce && wr;

	always_comb begin
		port_sel = io_none;
		if (in_window) begin
			case (addr[7:0])
				port_mmca: port_sel = io_mmca;
				port_spdr: port_sel = io_spdr;
				port_spsr: port_sel = io_spsr;
				port_txd: port_sel = io_txd;
				port_ctl: port_sel = io_ctl;
				port_tmr1: port_sel = io_tmr1;
				port_tmr2: port_sel = io_tmr2;
				port_led: port_sel = io_led;
				default: port_sel = io_none;
			endcase
		end
	end

	// Read code follows the address every cycle, write pulses only on strobe
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			rd_port <= io_none;
			wr_txd <= 1'b0;
			wr_spdr <= 1'b0;
			wr_tmr1 <= 1'b0;
			wr_tmr2 <= 1'b0;
			wr_mmca <= 1'b0;
			wr_led <= 1'b0;
		end else begin
			rd_port <= port_sel;
			wr_txd <= wr_hit && port_sel == io_txd;
			wr_spdr <= wr_hit && port_sel == io_spdr;
			wr_tmr1 <= wr_hit && port_sel == io_tmr1;
			wr_tmr2 <= wr_hit && port_sel == io_tmr2;
			wr_mmca <= wr_hit && port_sel == io_mmca;
			wr_led <= wr_hit && port_sel == io_led;
		end
	end

	// Data byte lines up with the pulses
	always_ff @(posedge clk) begin
		wdata_q <= wdata;
	end

endmodule

/* logic/fdc_pkg.sv */
package fdc_pkg;

	////////////////////////////////////////////////////////////
	// I/O window and port offsets
	////////////////////////////////////////////////////////////

	// 256-byte window starting here
	localparam logic [15:0] io_base = 16'hE000;

	localparam logic [7:0] port_mmca = 8'd0;
	localparam logic [7:0] port_spdr = 8'd1;
	localparam logic [7:0] port_spsr = 8'd2;
	localparam logic [7:0] port_txd = 8'd4;
	localparam logic [7:0] port_ctl = 8'd6;
	localparam logic [7:0] port_tmr1 = 8'd7;
	localparam logic [7:0] port_tmr2 = 8'd8;
	localparam logic [7:0] port_led = 8'd16;

	////////////////////////////////////////////////////////////
	// Rate dividers
	////////////////////////////////////////////////////////////

	// Clock cycles per serial bit, 2 or more
	localparam int uart_div = 8;
	// Clock cycles per half sck period, 1 or more
	localparam int spi_half = 2;
	// Clock cycles per timer decrement, 2 or more
	localparam int tick_div = 20;

	////////////////////////////////////////////////////////////
	// Port codes and FSM states
	////////////////////////////////////////////////////////////

	// Decoded port, io_none for anything unmapped
	typedef enum logic [3:0] {
		io_none,
		io_mmca,
		io_spdr,
		io_spsr,
		io_txd,
		io_ctl,
		io_tmr1,
		io_tmr2,
		io_led
	} io_port_e;

	typedef enum logic [1:0] {tx_idle, tx_start, tx_data, tx_stop} uart_state_e;

	typedef enum logic [0:0] {spi_idle, spi_shift} spi_state_e;

endpackage
